// File: include/pat_defines.svh
`ifndef PAT_DEFINES_SVH
`define PAT_DEFINES_SVH

// ==========================================================================
// core widths
// ==========================================================================

`define PAT_IW 23 // instruction word
`define PAT_DW 8 // data path and register width
`define PAT_RN_W 3 // register index
`define PAT_NREGS 8 // register file depth
`define PAT_PC_W 10 // program counter

// ==========================================================================
// pipeline control
// ==========================================================================

// instructions thrown away at commit once a branch is taken
`define PAT_BRANCH_SHADOW 5

// i0 nop with condition always and all reserved bits zero
// rn=000 fp=00000 cond=11 fo=0 1111 1111 0101
`define PAT_INSTR_NOP 23'h006ff5

`endif

// File: design/pat_pkg.sv
`include "pat_defines.svh"

package pat_pkg;

	// i8 opcodes, 1111 escapes to the i3 space
	typedef enum logic [3:0] {
		OP8_ORI    = 4'b0000,
		OP8_ORR    = 4'b0001,
		OP8_ANDI   = 4'b0010,
		OP8_ANDR   = 4'b0011,
		OP8_ADDI   = 4'b0100,
		OP8_ADDR   = 4'b0101,
		OP8_SUBI   = 4'b0110,
		OP8_SUBR   = 4'b0111,
		OP8_LDI    = 4'b1000,
		OP8_BF     = 4'b1101,
		OP8_PREFIX = 4'b1111
	} opcode8_e;

	// i3 opcodes, bit 0 picks register form for the shifts
	typedef enum logic [3:0] {
		OP3_SHLZI  = 4'b0000,
		OP3_SHLZR  = 4'b0001,
		OP3_SHLOI  = 4'b0010,
		OP3_SHLOR  = 4'b0011,
		OP3_SHRZI  = 4'b0100,
		OP3_SHRZR  = 4'b0101,
		OP3_SHROI  = 4'b0110,
		OP3_SHROR  = 4'b0111,
		OP3_IN     = 4'b1000,
		OP3_OUT    = 4'b1011,
		OP3_PREFIX = 4'b1111
	} opcode3_e;

	typedef enum logic [3:0] {
		OP0_NOT  = 4'b0000,
		OP0_TEST = 4'b0010,
		OP0_NOP  = 4'b0101
	} opcode0_e;

	typedef enum logic [1:0] {
		COND_Z  = 2'd0, // zero flag set
		COND_NZ = 2'd1, // zero flag clear
		COND_N  = 2'd2, // negative flag set
		COND_AL = 2'd3  // unconditional
	} cond_e;

	// i8 format, full byte immediate
	typedef struct packed {
		logic [`PAT_RN_W-1:0] rn;
		logic [4:0]           fieldp; // reserved, zero
		cond_e                cond;
		logic                 field_op; // reserved, zero
		opcode8_e             op8;
		logic [7:0]           imm;
	} instr_i8_t;

	// i3 and i0 formats share this layout under the 1111 prefix
	typedef struct packed {
		logic [`PAT_RN_W-1:0] rn;
		logic [4:0]           fieldp;
		cond_e                cond;
		logic                 field_op;
		logic [3:0]           prefix;
		opcode3_e             op3;
		logic [3:0]           low; // i0 opcode, or imm3 in [2:0]
	} instr_short_t;

	typedef union packed {
		instr_i8_t    i8;
		instr_short_t sh;
	} instr_u;

	// operation class seen by the alu
	typedef enum logic [3:0] {
		ALU_OR,
		ALU_AND,
		ALU_ADD,
		ALU_SUB,
		ALU_NOT,
		ALU_SHLZ,
		ALU_SHLO,
		ALU_SHRZ,
		ALU_SHRO,
		ALU_PASS // forwards operand b (ldi, in)
	} alu_op_e;

endpackage

// File: design/pat_stage_if.sv
`timescale 1ns/1ps
`include "pat_defines.svh"

// decode -> execute
interface pat_dx_if;
	import pat_pkg::*;

	logic                 valid; // real instruction, nop and unknown give 0
	alu_op_e              alu_op;
	logic [`PAT_RN_W-1:0] rn;
	logic [`PAT_DW-1:0]   a; // Rn contents
	logic [`PAT_DW-1:0]   b; // immediate, Rm or input byte
	cond_e                cond;
	logic                 wr_reg;
	logic                 is_out;
	logic                 is_test;
	logic                 is_branch;
	logic [`PAT_DW-1:0]   offset; // bf displacement, signed

	modport src (output valid, alu_op, rn, a, b, cond, wr_reg, is_out, is_test,
		is_branch, offset);
	modport dst (input valid, alu_op, rn, a, b, cond, wr_reg, is_out, is_test,
		is_branch, offset);
endinterface

// execute -> commit
interface pat_xc_if;
	import pat_pkg::*;

	logic                 valid;
	logic [`PAT_DW-1:0]   result;
	logic [`PAT_RN_W-1:0] rn;
	cond_e                cond;
	logic                 wr_reg;
	logic                 is_out;
	logic                 is_test;
	logic                 is_branch;
	logic [`PAT_DW-1:0]   offset;
	logic [`PAT_DW-1:0]   test_value; // Rn for test and out

	modport src (output valid, result, rn, cond, wr_reg, is_out, is_test,
		is_branch, offset, test_value);
	modport dst (input valid, result, rn, cond, wr_reg, is_out, is_test,
		is_branch, offset, test_value);
endinterface

// File: design/pat_regfile.sv
`timescale 1ns/1ps
`include "pat_defines.svh"

module pat_regfile (
	input  logic                 clk,
	input  logic [`PAT_RN_W-1:0] i_rd_a_idx, // Rn
	input  logic [`PAT_RN_W-1:0] i_rd_b_idx, // Rm
	output logic [`PAT_DW-1:0]   o_rd_a,
	output logic [`PAT_DW-1:0]   o_rd_b,
	input  logic                 i_wr_en,
	input  logic [`PAT_RN_W-1:0] i_wr_idx,
	input  logic [`PAT_DW-1:0]   i_wr_data
);

	logic [`PAT_DW-1:0] regs [`PAT_NREGS];

	// read ports are plain muxes
	assign o_rd_a = regs[i_rd_a_idx];
	assign o_rd_b = regs[i_rd_b_idx];

	// single write port from commit
	always_ff @(posedge clk)
	begin
		if (i_wr_en)
			regs[i_wr_idx] <= i_wr_data;
	end

endmodule

// File: design/pat_decode.sv
`timescale 1ns/1ps
`include "pat_defines.svh"

module pat_decode (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [`PAT_IW-1:0]   i_instr,
	input  logic [`PAT_DW-1:0]   i_in0,
	input  logic [`PAT_DW-1:0]   i_in1,
	input  logic [`PAT_DW-1:0]   i_in2,
	output logic [`PAT_RN_W-1:0] o_rd_a_idx,
	output logic [`PAT_RN_W-1:0] o_rd_b_idx,
	input  logic [`PAT_DW-1:0]   i_rd_a,
	input  logic [`PAT_DW-1:0]   i_rd_b,
	pat_dx_if.src                dx
);
	import pat_pkg::*;

	instr_u             ir; // instruction register
	logic               is_i8, is_i3;
	logic [2:0]         imm3;
	logic [`PAT_DW-1:0] imm3_ext;
	logic [`PAT_DW-1:0] in_sel;
	logic               d_valid, d_wr, d_out, d_test, d_br;
	alu_op_e            d_op;
	logic [`PAT_DW-1:0] d_b;

	always_ff @(posedge clk)
	begin
		if (reset)
			ir <= `PAT_INSTR_NOP;
		else
			ir <= i_instr;
	end

	// format from the two prefix levels, anything left is i0
	assign is_i8 = (ir.i8.op8 != OP8_PREFIX);
	assign is_i3 = !is_i8 && (ir.sh.op3 != OP3_PREFIX);

	assign imm3     = ir.sh.low[2:0];
	assign imm3_ext = {{(`PAT_DW-3){1'b0}}, imm3};

	assign o_rd_a_idx = ir.i8.rn;
	assign o_rd_b_idx = imm3; // Rm sits in the low immediate bits

	// one-hot input pick, in0 when the code is not one-hot
	always_comb
	begin
		case (imm3)
			3'b010:  in_sel = i_in1;
			3'b100:  in_sel = i_in2;
			default: in_sel = i_in0;
		endcase
	end

	// ==========================================================================
	// opcode to operation class
	// ==========================================================================

	always_comb
	begin
		d_valid = 1'b1;
		d_wr    = 1'b1; // most ops write Rn
		d_out   = 1'b0;
		d_test  = 1'b0;
		d_br    = 1'b0;
		d_op    = ALU_PASS;
		d_b     = ir.i8.imm;
		if (is_i8)
		begin
			if (ir.i8.op8[0] && !ir.i8.op8[3])
				d_b = i_rd_b; // register form of or/and/add/sub
			case (ir.i8.op8)
				OP8_ORI, OP8_ORR:   d_op = ALU_OR;
				OP8_ANDI, OP8_ANDR: d_op = ALU_AND;
				OP8_ADDI, OP8_ADDR: d_op = ALU_ADD;
				OP8_SUBI, OP8_SUBR: d_op = ALU_SUB;
				OP8_LDI:            d_op = ALU_PASS;
				OP8_BF:
				begin
					d_wr = 1'b0;
					d_br = 1'b1;
				end
				default:
				begin
					d_valid = 1'b0; // unused i8 code
					d_wr    = 1'b0;
				end
			endcase
		end
		else if (is_i3)
		begin
			d_b = ir.sh.op3[0] ? i_rd_b : imm3_ext; // shift amount source
			case (ir.sh.op3)
				OP3_SHLZI, OP3_SHLZR: d_op = ALU_SHLZ;
				OP3_SHLOI, OP3_SHLOR: d_op = ALU_SHLO;
				OP3_SHRZI, OP3_SHRZR: d_op = ALU_SHRZ;
				OP3_SHROI, OP3_SHROR: d_op = ALU_SHRO;
				OP3_IN:               d_b  = in_sel;
				OP3_OUT:
				begin
					d_wr  = 1'b0;
					d_out = 1'b1;
				end
				default:
				begin
					d_valid = 1'b0;
					d_wr    = 1'b0;
				end
			endcase
		end
		else
		begin
			case (ir.sh.low)
				OP0_NOT:  d_op = ALU_NOT;
				OP0_TEST:
				begin
					d_wr   = 1'b0;
					d_test = 1'b1;
				end
				default: // nop and unknown i0
				begin
					d_valid = 1'b0;
					d_wr    = 1'b0;
				end
			endcase
		end
	end

	// stage register toward execute
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			dx.valid     <= 1'b0;
			dx.wr_reg    <= 1'b0;
			dx.is_out    <= 1'b0;
			dx.is_test   <= 1'b0;
			dx.is_branch <= 1'b0;
		end
		else
		begin
			dx.valid     <= d_valid;
			dx.wr_reg    <= d_wr;
			dx.is_out    <= d_out;
			dx.is_test   <= d_test;
			dx.is_branch <= d_br;
		end
		dx.alu_op <= d_op;
		dx.rn     <= ir.i8.rn;
		dx.a      <= i_rd_a;
		dx.b      <= d_b;
		dx.cond   <= ir.i8.cond;
		dx.offset <= ir.i8.imm; // only meaningful for bf
	end

endmodule

// File: design/pat_alu.sv
`timescale 1ns/1ps
`include "pat_defines.svh"

module pat_alu (
	input  pat_pkg::alu_op_e   i_op,
	input  logic [`PAT_DW-1:0] i_a,
	input  logic [`PAT_DW-1:0] i_b,
	output logic [`PAT_DW-1:0] o_y
);
	import pat_pkg::*;

	logic [2:0]         sh_amt; // 1..4
	logic [`PAT_DW-1:0] shlz, shlo, shrz, shro;

	assign sh_amt = {1'b0, i_b[1:0]} + 3'd1;

	// ==========================================================================
	// shifter
	// ==========================================================================

	assign shlz = i_a << sh_amt;
	assign shrz = i_a >> sh_amt;
	// one-fill is the zero-fill shift done on the inverted word
	assign shlo = ~((~i_a) << sh_amt); // ones enter at bit 0
	assign shro = ~((~i_a) >> sh_amt); // ones enter at the msb

	// result select
	always_comb
	begin
		case (i_op)
			ALU_OR:   o_y = i_a | i_b;
			ALU_AND:  o_y = i_a & i_b;
			ALU_ADD:  o_y = i_a + i_b; // wraps, no carry kept
			ALU_SUB:  o_y = i_a - i_b;
			ALU_NOT:  o_y = ~i_a;
			ALU_SHLZ: o_y = shlz;
			ALU_SHLO: o_y = shlo;
			ALU_SHRZ: o_y = shrz;
			ALU_SHRO: o_y = shro;
			default:  o_y = i_b; // pass
		endcase
	end

endmodule

// File: design/pat_execute.sv
`timescale 1ns/1ps
`include "pat_defines.svh"

module pat_execute (
	input logic   clk,
	input logic   reset,
	pat_dx_if.dst dx,
	pat_xc_if.src xc
);

	logic [`PAT_DW-1:0] alu_y;

	pat_alu u_alu (
		.i_op (dx.alu_op),
		.i_a  (dx.a),
		.i_b  (dx.b),
		.o_y  (alu_y)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			xc.valid     <= 1'b0;
			xc.wr_reg    <= 1'b0;
			xc.is_out    <= 1'b0;
			xc.is_test   <= 1'b0;
			xc.is_branch <= 1'b0;
		end
		else
		begin
			xc.valid     <= dx.valid;
			xc.wr_reg    <= dx.wr_reg;
			xc.is_out    <= dx.is_out;
			xc.is_test   <= dx.is_test;
			xc.is_branch <= dx.is_branch;
		end
		xc.result     <= alu_y;
		xc.rn         <= dx.rn; // destination travels with the result
		xc.cond       <= dx.cond; // checked at commit, not here
		xc.offset     <= dx.offset;
		xc.test_value <= dx.a; // Rn as read in decode
	end

endmodule

// File: design/pat_commit.sv
`timescale 1ns/1ps
`include "pat_defines.svh"

module pat_commit (
	input  logic                 clk,
	input  logic                 reset,
	pat_xc_if.dst                xc,
	output logic                 o_wr_en,
	output logic [`PAT_RN_W-1:0] o_wr_idx,
	output logic [`PAT_DW-1:0]   o_wr_data,
	output logic [`PAT_PC_W-1:0] o_pc,
	output logic                 o_jump,
	output logic [`PAT_DW-1:0]   o_out,
	output logic                 o_out_valid
);
	import pat_pkg::*;

	localparam int SH_W = $clog2(`PAT_BRANCH_SHADOW + 1);

	logic                 flag_z; // zero
	logic                 flag_n; // negative
	logic [SH_W-1:0]      shadow_cnt; // instructions still to drop
	logic                 cond_ok;
	logic                 fire; // instruction takes effect this cycle
	logic                 taken; // bf that fires
	logic [`PAT_PC_W-1:0] offset_ext;

	// ==========================================================================
	// condition and shadow gating
	// ==========================================================================

	always_comb
	begin
		case (xc.cond)
			COND_Z:  cond_ok = flag_z;
			COND_NZ: cond_ok = !flag_z;
			COND_N:  cond_ok = flag_n;
			default: cond_ok = 1'b1; // always
		endcase
	end

	assign fire  = xc.valid && cond_ok && (shadow_cnt == '0);
	assign taken = fire && xc.is_branch;

	// write-back lands on the next edge
	assign o_wr_en   = fire && xc.wr_reg;
	assign o_wr_idx  = xc.rn;
	assign o_wr_data = xc.result;

	assign offset_ext = {{(`PAT_PC_W-`PAT_DW){xc.offset[`PAT_DW-1]}}, xc.offset};

	// ==========================================================================
	// flags, strobes, pc
	// ==========================================================================

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			flag_z      <= 1'b0;
			flag_n      <= 1'b0;
			shadow_cnt  <= '0;
			o_pc        <= '0;
			o_jump      <= 1'b0;
			o_out       <= '0;
			o_out_valid <= 1'b0;
		end
		else
		begin
			o_jump      <= taken; // single-cycle pulse
			o_out_valid <= fire && xc.is_out;
			if (fire && xc.is_out)
				o_out <= xc.test_value;
			if (fire && xc.is_test)
			begin
				flag_z <= (xc.test_value == '0);
				flag_n <= xc.test_value[`PAT_DW-1];
			end
			// shadow loads on a taken bf and drains one per cycle
			if (taken)
				shadow_cnt <= SH_W'(`PAT_BRANCH_SHADOW);
			else if (shadow_cnt != '0)
				shadow_cnt <= shadow_cnt - 1'b1;
			if (taken)
				o_pc <= o_pc + offset_ext; // relative, either direction
			else
				o_pc <= o_pc + 1'b1;
		end
	end

endmodule

// File: design/pat_top.sv
`timescale 1ns/1ps
`include "pat_defines.svh"

module pat_top (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [`PAT_IW-1:0]   i_instr,
	input  logic [`PAT_DW-1:0]   i_in0,
	input  logic [`PAT_DW-1:0]   i_in1,
	input  logic [`PAT_DW-1:0]   i_in2,
	output logic [`PAT_PC_W-1:0] o_pc,
	output logic                 o_jump,
	output logic [`PAT_DW-1:0]   o_out,
	output logic                 o_out_valid
);

	logic [`PAT_RN_W-1:0] rd_a_idx, rd_b_idx;
	logic [`PAT_DW-1:0]   rd_a, rd_b;
	logic                 wr_en;
	logic [`PAT_RN_W-1:0] wr_idx;
	logic [`PAT_DW-1:0]   wr_data;

	pat_dx_if u_dx (); // decode -> execute
	pat_xc_if u_xc (); // execute -> commit

	pat_regfile u_regfile (
		.clk        (clk),
		.i_rd_a_idx (rd_a_idx),
		.i_rd_b_idx (rd_b_idx),
		.o_rd_a     (rd_a),
		.o_rd_b     (rd_b),
		.i_wr_en    (wr_en),
		.i_wr_idx   (wr_idx),
		.i_wr_data  (wr_data)
	);

	pat_decode u_decode (
		.clk        (clk),
		.reset      (reset),
		.i_instr    (i_instr),
		.i_in0      (i_in0),
		.i_in1      (i_in1),
		.i_in2      (i_in2),
		.o_rd_a_idx (rd_a_idx),
		.o_rd_b_idx (rd_b_idx),
		.i_rd_a     (rd_a),
		.i_rd_b     (rd_b),
		.dx         (u_dx.src)
	);

	pat_execute u_execute (
		.clk   (clk),
		.reset (reset),
		.dx    (u_dx.dst),
		.xc    (u_xc.src)
	);

	pat_commit u_commit (
		.clk         (clk),
		.reset       (reset),
		.xc          (u_xc.dst),
		.o_wr_en     (wr_en),
		.o_wr_idx    (wr_idx),
		.o_wr_data   (wr_data),
		.o_pc        (o_pc),
		.o_jump      (o_jump),
		.o_out       (o_out),
		.o_out_valid (o_out_valid)
	);

endmodule

// File: verification/pat_assert.sv
`timescale 1ns/1ps
`include "pat_defines.svh"

module pat_assert (
	input logic clk,
	input logic reset,
	input logic i_jump, // o_jump of the core
	input logic i_out_valid // o_out_valid of the core
);

	int fail_cnt = 0; // failed assertions so far

	// strobes cleared by reset and still low one cycle after it drops
	a_reset_quiet: assert property (@(posedge clk)
		reset |=> (!i_jump && !i_out_valid) [*2])
		else
		begin
			$error("strobe high during or right after reset");
			fail_cnt++;
		end

	// a taken branch is a one-cycle pulse
	a_jump_single: assert property (@(posedge clk) disable iff (reset)
		i_jump |=> !i_jump)
		else
		begin
			$error("o_jump high for two cycles");
			fail_cnt++;
		end

	// shadow instructions after a jump must stay silent
	a_shadow_quiet: assert property (@(posedge clk) disable iff (reset)
		i_jump |=> (!i_jump && !i_out_valid) [*`PAT_BRANCH_SHADOW])
		else
		begin
			$error("strobe inside the branch shadow");
			fail_cnt++;
		end

endmodule

bind pat_top pat_assert u_assert (
	.clk         (clk),
	.reset       (reset),
	.i_jump      (o_jump),
	.i_out_valid (o_out_valid)
);

// File: verification/pat_tb.sv
`timescale 1ns/1ps
`include "pat_defines.svh"

module pat_tb;
	import pat_pkg::*;

	localparam int WAIT_MAX = 50; // cycles allowed for pending strobes

	logic                 clk;
	logic                 reset;
	logic [`PAT_IW-1:0]   i_instr;
	logic [`PAT_DW-1:0]   i_in0, i_in1, i_in2;
	logic [`PAT_PC_W-1:0] o_pc;
	logic                 o_jump;
	logic [`PAT_DW-1:0]   o_out;
	logic                 o_out_valid;

	// architectural model
	logic [`PAT_DW-1:0] m_regs [`PAT_NREGS];
	logic               m_z = 1'b0;
	logic               m_n = 1'b0;
	int                 m_shadow = 0; // instructions still to drop
	logic [`PAT_DW-1:0] exp_out_q [$]; // bytes due on o_out in order
	logic [`PAT_DW-1:0] exp_off_q [$]; // offsets of jumps due

	int unsigned          lcg_state = 51715; // seed
	int                   err_cnt = 0;
	int                   check_cnt = 0;
	int                   test_err = 0; // errors before the running test
	logic [`PAT_PC_W-1:0] last_pc; // o_pc one cycle back
	logic [`PAT_PC_W-1:0] exp_pc;
	logic                 armed; // pc tracking valid
	logic [`PAT_DW-1:0]   exp_byte;
	logic [`PAT_DW-1:0]   exp_off;

	pat_top u_dut (
		.clk         (clk),
		.reset       (reset),
		.i_instr     (i_instr),
		.i_in0       (i_in0),
		.i_in1       (i_in1),
		.i_in2       (i_in2),
		.o_pc        (o_pc),
		.o_jump      (o_jump),
		.o_out       (o_out),
		.o_out_valid (o_out_valid)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	// ========================================================================
	// stimulus helpers
	// ========================================================================

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = lcg_next();
		return r[23:16]; // upper bits mix better
	endfunction

	function automatic logic [`PAT_IW-1:0] enc_i8(input logic [2:0] rn,
		input logic [1:0] cond, input logic [3:0] op, input logic [7:0] imm);
		return {rn, 5'b0, cond, 1'b0, op, imm};
	endfunction

	function automatic logic [`PAT_IW-1:0] enc_i3(input logic [2:0] rn,
		input logic [1:0] cond, input logic [3:0] op, input logic [2:0] imm3);
		return {rn, 5'b0, cond, 1'b0, 4'hf, op, 1'b0, imm3};
	endfunction

	function automatic logic [`PAT_IW-1:0] enc_i0(input logic [2:0] rn,
		input logic [1:0] cond, input logic [3:0] op);
		return {rn, 5'b0, cond, 1'b0, 4'hf, 4'hf, op};
	endfunction

	// ========================================================================
	// reference model called once per instruction reaching commit
	// ========================================================================

	function automatic void ref_exec(input logic [`PAT_IW-1:0] w);
		logic [2:0] rn, rm;
		logic [3:0] op8, op3;
		logic [7:0] a, b, y;
		logic       ok, wr;
		int         amt;
		rn  = w[22:20];
		op8 = w[11:8];
		op3 = w[7:4];
		rm  = w[2:0]; // Rm, imm3 or input code
		if (m_shadow > 0)
		begin
			m_shadow--; // dropped behind a taken branch
			return;
		end
		case (w[14:13])
			2'd0:    ok = m_z;
			2'd1:    ok = !m_z;
			2'd2:    ok = m_n;
			default: ok = 1'b1;
		endcase
		if (!ok)
			return;
		a  = m_regs[rn];
		y  = a;
		wr = 1'b1;
		if (op8 != 4'hf)
		begin
			b = (op8 < 4'h8 && op8[0]) ? m_regs[rm] : w[7:0]; // odd low codes use Rm
			case (op8)
				4'h0, 4'h1: y = a | b;
				4'h2, 4'h3: y = a & b;
				4'h4, 4'h5: y = a + b;
				4'h6, 4'h7: y = a - b;
				4'h8:       y = b;
				4'hd:
				begin
					wr = 1'b0;
					exp_off_q.push_back(w[7:0]);
					m_shadow = `PAT_BRANCH_SHADOW;
				end
				default:    wr = 1'b0; // unused code
			endcase
		end
		else if (op3 != 4'hf)
		begin
			b   = op3[0] ? m_regs[rm] : {5'b0, rm};
			amt = b[1:0] + 1; // one to four places
			case (op3)
				4'h0, 4'h1: y = a << amt;
				4'h2, 4'h3: y = (a << amt) | ((8'd1 << amt) - 8'd1);
				4'h4, 4'h5: y = a >> amt;
				4'h6, 4'h7: y = (a >> amt) | ~(8'hff >> amt);
				4'h8:       y = (rm == 3'b010) ? i_in1 : (rm == 3'b100) ? i_in2 : i_in0;
				4'hb:
				begin
					wr = 1'b0;
					exp_out_q.push_back(a);
				end
				default:    wr = 1'b0;
			endcase
		end
		else
		begin
			case (w[3:0])
				4'h0: y = ~a;
				4'h2:
				begin
					wr  = 1'b0;
					m_z = (a == 8'd0);
					m_n = a[7];
				end
				default: wr = 1'b0; // nop and unused i0
			endcase
		end
		if (wr)
			m_regs[rn] = y;
	endfunction

	// one instruction per cycle driven 1 ns after the edge
	task automatic send_word(input logic [`PAT_IW-1:0] w);
		i_instr = w;
		ref_exec(w);
		@(posedge clk);
		#1;
	endtask

	// two trailing nops clear the register hazard
	task automatic issue(input logic [`PAT_IW-1:0] w);
		send_word(w);
		send_word(`PAT_INSTR_NOP);
		send_word(`PAT_INSTR_NOP);
	endtask

	task automatic wait_strobes(input string name);
		int n;
		n = 0;
		while ((exp_out_q.size() != 0 || exp_off_q.size() != 0) && n < WAIT_MAX)
		begin
			send_word(`PAT_INSTR_NOP);
			n++;
		end
		if (exp_out_q.size() != 0 || exp_off_q.size() != 0)
		begin
			$display("%s: %0d expected strobes never arrived within %0d cycles", name,
				exp_out_q.size() + exp_off_q.size(), WAIT_MAX);
			err_cnt++;
			exp_out_q.delete();
			exp_off_q.delete();
		end
	endtask

	task automatic finish_test(input string name);
		wait_strobes(name);
		repeat (6)
			send_word(`PAT_INSTR_NOP); // window for stray strobes
		$display("test %s done, %0d errors", name, err_cnt - test_err);
		test_err = err_cnt;
	endtask

	// ========================================================================
	// comparison process sampling at the falling edge
	// ========================================================================

	initial
	begin
		armed = 1'b0;
		forever
		begin
			@(negedge clk);
			if (o_out_valid === 1'b1)
			begin
				assert (exp_out_q.size() != 0) else
				begin
					$display("unexpected o_out_valid pulse, o_out 0x%02h", o_out);
					err_cnt++;
				end
				if (exp_out_q.size() != 0)
				begin
					exp_byte = exp_out_q.pop_front();
					check_cnt++;
					assert (o_out == exp_byte) else
					begin
						$display("[ERROR] o_out exp 0x%02h got 0x%02h", exp_byte, o_out);
						err_cnt++;
					end
				end
			end
			if (o_jump === 1'b1)
			begin
				assert (exp_off_q.size() != 0) else
				begin
					$display("unexpected o_jump pulse at o_pc 0x%03h", o_pc);
					err_cnt++;
				end
				if (exp_off_q.size() != 0)
				begin
					exp_off = exp_off_q.pop_front();
					exp_pc  = last_pc + {{(`PAT_PC_W-`PAT_DW){exp_off[7]}}, exp_off};
					check_cnt++;
					assert (o_pc == exp_pc) else
					begin
						$display("[ERROR] o_pc exp 0x%03h got 0x%03h", exp_pc, o_pc);
						err_cnt++;
					end
				end
			end
			else if (armed)
			begin
				exp_pc = last_pc + 1'b1; // plain increment
				assert (o_pc == exp_pc) else
				begin
					$display("[ERROR] o_pc exp 0x%03h got 0x%03h", exp_pc, o_pc);
					err_cnt++;
				end
			end
			armed   = !reset;
			last_pc = o_pc;
		end
	end

	// ========================================================================
	// test sequence
	// ========================================================================

	initial
	begin
		logic [7:0] rv;
		logic [7:0] off;
		logic [2:0] rn, rm;
		logic [3:0] op;
		int         j;
		int         n;
		reset   = 1'b1;
		i_instr = `PAT_INSTR_NOP;
		i_in0   = 8'h00;
		i_in1   = 8'h00;
		i_in2   = 8'h00;
		repeat (10)
			@(posedge clk);
		#1;
		reset = 1'b0;

		// registers come up unknown
		for (int r = 0; r < `PAT_NREGS; r++)
			issue(enc_i8(3'(r), COND_AL, OP8_LDI, rand_byte()));

		// immediate forms use the even i8 codes plus ldi
		for (int k = 0; k < 20; k++)
		begin
			rv = rand_byte();
			rn = rv[2:0];
			j  = k % 5;
			op = (j == 4) ? OP8_LDI : 4'(2 * j);
			issue(enc_i8(rn, COND_AL, op, rand_byte()));
			issue(enc_i3(rn, COND_AL, OP3_OUT, 3'd0));
		end
		finish_test("immediate");

		// register forms plus not and shifts in both forms
		for (int k = 0; k < 26; k++)
		begin
			rv = rand_byte();
			rn = rv[2:0];
			rm = rv[6:4];
			j  = k % 13;
			issue(enc_i8(rn, COND_AL, OP8_LDI, rand_byte()));
			if (j < 4)
				issue(enc_i8(rn, COND_AL, 4'(2 * j + 1), {5'b0, rm}));
			else if (j == 4)
				issue(enc_i0(rn, COND_AL, OP0_NOT));
			else
				issue(enc_i3(rn, COND_AL, 4'(j - 5), rm)); // rm doubles as amount
			issue(enc_i3(rn, COND_AL, OP3_OUT, 3'd0));
		end
		finish_test("register_shift");

		// input select where the last code is not one-hot
		for (int round = 0; round < 2; round++)
		begin
			i_in0 = rand_byte();
			i_in1 = rand_byte();
			i_in2 = rand_byte();
			for (int c = 0; c < 4; c++)
			begin
				rv = rand_byte();
				rm = (c < 3) ? 3'(1 << c) : 3'b110;
				issue(enc_i3(rv[2:0], COND_AL, OP3_IN, rm));
				issue(enc_i3(rv[2:0], COND_AL, OP3_OUT, 3'd0));
			end
		end
		finish_test("inputs");

		// flags from zero, negative and positive values
		rv = rand_byte();
		issue(enc_i8(3'd1, COND_AL, OP8_LDI, 8'h00));
		issue(enc_i8(3'd2, COND_AL, OP8_LDI, rv | 8'h80));
		issue(enc_i8(3'd3, COND_AL, OP8_LDI, (rv & 8'h7f) | 8'h01));
		for (int t = 1; t <= 3; t++)
		begin
			issue(enc_i0(3'(t), COND_AL, OP0_TEST));
			for (int c = 0; c < 4; c++)
			begin
				issue(enc_i8(3'd4, 2'(c), OP8_LDI, rand_byte()));
				issue(enc_i3(3'd4, 2'(c), OP3_OUT, 3'd0));
			end
		end
		finish_test("conditions");

		// forward branch with five outs in the shadow and one after it
		rv  = rand_byte();
		off = {2'b00, rv[5:0]} + 8'd1;
		issue(enc_i8(3'd5, COND_AL, OP8_LDI, rand_byte()));
		send_word(enc_i8(3'd0, COND_AL, OP8_BF, off));
		for (int s = 0; s <= `PAT_BRANCH_SHADOW; s++)
			send_word(enc_i3(3'd5, COND_AL, OP3_OUT, 3'd0));
		wait_strobes("branch_fwd");

		// step back until the pc is low and then wrap through zero
		n = 0;
		while (o_pc > 10'd60 && n < 12)
		begin
			issue(enc_i8(3'd0, COND_AL, OP8_BF, 8'h80));
			wait_strobes("branch_back");
			repeat (6)
				send_word(`PAT_INSTR_NOP);
			n++;
		end
		issue(enc_i8(3'd0, COND_AL, OP8_BF, 8'h80));
		wait_strobes("branch_wrap");
		repeat (6)
			send_word(`PAT_INSTR_NOP);

		// zero flag is clear so a bf on zero must not jump
		issue(enc_i8(3'd6, COND_AL, OP8_LDI, rand_byte() | 8'h01));
		issue(enc_i0(3'd6, COND_AL, OP0_TEST));
		issue(enc_i8(3'd0, COND_Z, OP8_BF, 8'h10));
		issue(enc_i3(3'd6, COND_AL, OP3_OUT, 3'd0));
		finish_test("branches");

		err_cnt = err_cnt + u_dut.u_assert.fail_cnt;
		$display("summary: %0d checks, %0d errors, %0d assertion failures",
			check_cnt, err_cnt, u_dut.u_assert.fail_cnt);
		if (err_cnt == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: list.f
+incdir+include
design/pat_pkg.sv
design/pat_stage_if.sv
design/pat_regfile.sv
design/pat_decode.sv
design/pat_alu.sv
design/pat_execute.sv
design/pat_commit.sv
design/pat_top.sv
verification/pat_assert.sv
verification/pat_tb.sv
